// File: mod_vec_unit.f
src/mod_arith_pkg.sv
src/mod_add_sub.sv
src/coef_bank.sv
src/vec_sequencer.sv
src/apb_vec_regs.sv
src/mod_vec_unit.sv
verification/tb_mod_vec_unit.sv

// File: run_sim.sh
#!/bin/sh
# Compile the testbench and RTL with Verilator, then run the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_mod_vec_unit \
    -f mod_vec_unit.f -o sim_tb
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/sim_tb
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation ended with status $sim_status"
    exit 1
fi

echo "Simulation ended with status 0"
exit 0

// File: src/apb_vec_regs.sv
`timescale 1ns/1ps
// APB slave with CTRL and STATUS registers and windows onto banks A, B, C
// Bank reads take one wait state and errors complete at once with pslverr
module apb_vec_regs #(
    parameter int DEPTH = 64,
    parameter int IDX_W = 6
) (
    input  logic                             clk,
    input  logic                             reset_n,
    input  mod_arith_pkg::apb_req_t          apb_req_i,
    output mod_arith_pkg::apb_rsp_t          apb_rsp_o,
    input  logic                             busy_i,
    input  logic                             done_i,
    output logic                             start_o,
    output mod_arith_pkg::vec_cmd_t          cmd_o,
    output logic                             bank_we_a_o,
    output logic                             bank_we_b_o,
    output logic [IDX_W-1:0]                 bank_addr_o,
    output logic [mod_arith_pkg::COEF_W-1:0] bank_wdata_o,
    input  logic [mod_arith_pkg::COEF_W-1:0] bank_c_rdata_i,
    input  logic [mod_arith_pkg::COEF_W-1:0] bank_a_rdata_i,
    input  logic [mod_arith_pkg::COEF_W-1:0] bank_b_rdata_i
);

    localparam int AW = mod_arith_pkg::ADDR_W;
    localparam int CW = mod_arith_pkg::COEF_W;

    // Decode
    logic          access;
    logic [1:0]    region;
    logic [AW-3:0] word_idx;
    logic          sel_ctrl;
    logic          sel_status;
    logic          sel_a;
    logic          sel_b;
    logic          sel_c;
    logic          sel_bank;
    logic          bad_addr;
    logic          err;
    logic          bank_rd;
    logic          ctrl_wr;

    // State
    logic                    rd_wait;
    logic                    start_q;
    logic                    done_q;
    mod_arith_pkg::vec_cmd_t cmd_q;
    logic [mod_arith_pkg::DATA_W-1:0] rdata;

    // ====================
    // Address decode and errors
    // ====================
    always_comb begin
        access     = apb_req_i.psel && apb_req_i.penable;
        region     = apb_req_i.paddr[AW-1 -: 2];
        word_idx   = apb_req_i.paddr[AW-3:2];
        sel_ctrl   = apb_req_i.paddr == mod_arith_pkg::REG_CTRL;
        sel_status = apb_req_i.paddr == mod_arith_pkg::REG_STATUS;
        sel_a      = region == mod_arith_pkg::BANK_A_BASE[AW-1 -: 2];
        sel_b      = region == mod_arith_pkg::BANK_B_BASE[AW-1 -: 2];
        sel_c      = region == mod_arith_pkg::BANK_C_BASE[AW-1 -: 2];
        sel_bank   = sel_a || sel_b || sel_c;
        // Bank windows end at DEPTH words
        bad_addr   = sel_bank ? (word_idx >= DEPTH) : !(sel_ctrl || sel_status);
        err = bad_addr
            || (apb_req_i.pwrite && (sel_c || sel_status))
            || (sel_bank && busy_i)
            || (apb_req_i.pwrite && sel_ctrl && apb_req_i.pwdata[0] && busy_i);
        bank_rd    = sel_bank && !apb_req_i.pwrite && !err;
        ctrl_wr    = access && apb_req_i.pwrite && sel_ctrl && !err;
    end

    // Bank side
    assign bank_addr_o  = apb_req_i.paddr[IDX_W+1:2];
    assign bank_wdata_o = apb_req_i.pwdata[CW-1:0];
    assign bank_we_a_o  = access && apb_req_i.pwrite && sel_a && !err;
    assign bank_we_b_o  = access && apb_req_i.pwrite && sel_b && !err;

    // ====================
    // Read data
    // ====================
    always_comb begin
        rdata = '0;
        if (sel_ctrl) begin
            // Start reads back as 0
            rdata[14:8] = cmd_q.count;
            rdata[2]    = cmd_q.mlkem;
            rdata[1]    = cmd_q.sub;
        end else if (sel_status) begin
            rdata[1:0] = {done_q, busy_i};
        end else if (sel_a) begin
            rdata[CW-1:0] = bank_a_rdata_i;
        end else if (sel_b) begin
            rdata[CW-1:0] = bank_b_rdata_i;
        end else if (sel_c) begin
            rdata[CW-1:0] = bank_c_rdata_i;
        end
    end

    // Bank reads hold off pready for one access cycle
    assign apb_rsp_o.prdata  = rdata;
    assign apb_rsp_o.pready  = access && (!bank_rd || rd_wait);
    assign apb_rsp_o.pslverr = access && err;

    // ====================
    // Registers
    // ====================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_wait <= 1'b0;
            start_q <= 1'b0;
            done_q  <= 1'b0;
            cmd_q   <= '0;
        end else begin
            rd_wait <= access && bank_rd && !rd_wait;
            start_q <= ctrl_wr && apb_req_i.pwdata[0];
            if (ctrl_wr) begin
                cmd_q <= '{sub:   apb_req_i.pwdata[1],
                           mlkem: apb_req_i.pwdata[2],
                           count: apb_req_i.pwdata[14:8]};
            end
            // Done stays set until the next start is written
            if (ctrl_wr && apb_req_i.pwdata[0]) begin
                done_q <= 1'b0;
            end else if (done_i) begin
                done_q <= 1'b1;
            end
        end
    end

    assign start_o = start_q;
    assign cmd_o   = cmd_q;

endmodule

// File: src/coef_bank.sv
`timescale 1ns/1ps
// Coefficient memory with one write port and one registered read port
// Instantiated for banks A, B and C
module coef_bank #(
    parameter int DEPTH = 64,
    parameter int IDX_W = 6
) (
    input  logic                             clk,
    input  logic                             we_i,
    input  logic [IDX_W-1:0]                 waddr_i,
    input  logic [mod_arith_pkg::COEF_W-1:0] wdata_i,
    input  logic [IDX_W-1:0]                 raddr_i,
    output logic [mod_arith_pkg::COEF_W-1:0] rdata_o
);

    logic [mod_arith_pkg::COEF_W-1:0] mem [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // Read data shows up one cycle after the address
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

// File: src/mod_add_sub.sv
`timescale 1ns/1ps
// Two-stage pipelined modular adder/subtractor for ML-DSA and ML-KEM
// Accepts one pair per cycle and returns result and valid two edges later
module mod_add_sub (
    input  logic                            clk,
    input  logic                            reset_n,
    input  mod_arith_pkg::coef_op_t         op_i,
    input  logic                            op_valid_i,
    output logic [mod_arith_pkg::COEF_W-1:0] res_o,
    output logic                            res_valid_o
);

    localparam int W  = mod_arith_pkg::COEF_W;
    localparam int KW = mod_arith_pkg::KEM_W;

    // Stage 1 combinational
    logic [W-1:0] prime;
    logic [W-1:0] opb_eff;
    logic [W:0]   sum0;
    logic         carry0;
    logic [W-1:0] corr;

    // Stage 1 registers
    logic [W-1:0] s1_sum;
    logic         s1_carry;
    logic         s1_sub;
    logic         s1_mlkem;
    logic [W-1:0] s1_corr;

    // Stage 2 combinational
    logic [W:0]   sum1;
    logic         carry1;
    logic         use_corr;

    logic [1:0]   vld_sr;

    // ML-KEM keeps only the low KEM_W bits and forces the upper bits to zero
    function automatic logic [W-1:0] kem_mask(input logic [W-1:0] v, input logic mlkem);
        kem_mask = mlkem ? {{(W-KW){1'b0}}, v[KW-1:0]} : v;
    endfunction

    // ====================
    // Stage 1 forms a + b or a - b
    // ====================
    always_comb begin
        prime   = op_i.mlkem ? mod_arith_pkg::Q_MLKEM : mod_arith_pkg::Q_MLDSA;
        // Subtract as a + ~b + 1
        opb_eff = kem_mask(op_i.sub ? ~op_i.opb : op_i.opb, op_i.mlkem);
        sum0    = {1'b0, op_i.opa} + {1'b0, opb_eff} + (W+1)'(op_i.sub);
        carry0  = op_i.mlkem ? sum0[KW] : sum0[W];
        // Add q back after subtract, take q away after add
        corr    = kem_mask(op_i.sub ? prime : ~prime, op_i.mlkem);
    end

    always_ff @(posedge clk) begin
        if (op_valid_i) begin
            s1_sum   <= kem_mask(sum0[W-1:0], op_i.mlkem);
            s1_carry <= carry0;
            s1_sub   <= op_i.sub;
            s1_mlkem <= op_i.mlkem;
            s1_corr  <= corr;
        end
    end

    // ====================
    // Stage 2 corrects and selects
    // ====================
    always_comb begin
        // Carry-in completes the two's complement of q for an add
        sum1   = {1'b0, s1_sum} + {1'b0, s1_corr} + (W+1)'(!s1_sub);
        carry1 = s1_mlkem ? sum1[KW] : sum1[W];
        // An add with overflow or no borrow against q has reached q
        // A subtract without a stage-1 carry has wrapped below zero
        use_corr = s1_sub ? !s1_carry : (s1_carry | carry1);
    end

    always_ff @(posedge clk) begin
        res_o <= use_corr ? kem_mask(sum1[W-1:0], s1_mlkem) : s1_sum;
    end

    // Valid travels alongside the two data stages
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vld_sr <= 2'b00;
        end else begin
            vld_sr <= {vld_sr[0], op_valid_i};
        end
    end

    assign res_valid_o = vld_sr[1];

endmodule

// File: src/mod_arith_pkg.sv
// Shared constants and types for the modular vector add/sub unit
// Modules reference these by scoped name
package mod_arith_pkg;

    // ====================
    // Coefficient arithmetic
    // ====================

    // Width leaves headroom for the ML-DSA carry
    localparam int COEF_W = 24;
    // ML-KEM carry is taken at this bit
    localparam int KEM_W = 12;

    localparam logic [COEF_W-1:0] Q_MLDSA = 24'd8380417;
    localparam logic [COEF_W-1:0] Q_MLKEM = 24'd3329;

    // ====================
    // APB and register map
    // ====================

    localparam int ADDR_W = 12;
    localparam int DATA_W = 32;

    localparam logic [ADDR_W-1:0] REG_CTRL    = 12'h000;
    localparam logic [ADDR_W-1:0] REG_STATUS  = 12'h004;
    localparam logic [ADDR_W-1:0] BANK_A_BASE = 12'h400;
    localparam logic [ADDR_W-1:0] BANK_B_BASE = 12'h800;
    localparam logic [ADDR_W-1:0] BANK_C_BASE = 12'hC00;

    typedef struct packed {
        logic [ADDR_W-1:0] paddr;
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    // One operand pair with its mode bits
    typedef struct packed {
        logic              sub;
        logic              mlkem;
        logic [COEF_W-1:0] opa;
        logic [COEF_W-1:0] opb;
    } coef_op_t;

    // Vector command from the register block to the sequencer
    typedef struct packed {
        logic       sub;
        logic       mlkem;
        logic [6:0] count;
    } vec_cmd_t;

endpackage

// File: src/mod_vec_unit.sv
`timescale 1ns/1ps
// Top of the vector modular add/sub unit
// APB loads banks A and B, starts a run, and reads results from bank C
module mod_vec_unit #(
    parameter int DEPTH = 64
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  mod_arith_pkg::apb_req_t apb_req_i,
    output mod_arith_pkg::apb_rsp_t apb_rsp_o
);

    localparam int IDX_W = $clog2(DEPTH);
    localparam int CW    = mod_arith_pkg::COEF_W;

    // Register block side
    logic                    busy;
    logic                    done;
    logic                    start;
    mod_arith_pkg::vec_cmd_t cmd;
    logic                    reg_we_a;
    logic                    reg_we_b;
    logic [IDX_W-1:0]        reg_addr;
    logic [CW-1:0]           reg_wdata;

    // Bank read data
    logic [CW-1:0]           a_rdata;
    logic [CW-1:0]           b_rdata;
    logic [CW-1:0]           c_rdata;

    // Sequencer and pipeline
    logic [IDX_W-1:0]        seq_rd_addr;
    logic                    seq_wr_en;
    logic [IDX_W-1:0]        seq_wr_addr;
    logic [CW-1:0]           seq_wr_data;
    mod_arith_pkg::coef_op_t op;
    logic                    op_valid;
    logic [CW-1:0]           res;
    logic                    res_valid;

    // ====================
    // Bank ownership
    // ====================
    logic [IDX_W-1:0] ab_raddr;
    logic             a_we;
    logic             b_we;
    logic             c_we;

    // Sequencer owns A/B reads and C writes while busy
    assign ab_raddr = busy ? seq_rd_addr : reg_addr;
    assign a_we     = busy ? 1'b0 : reg_we_a;
    assign b_we     = busy ? 1'b0 : reg_we_b;
    assign c_we     = busy ? seq_wr_en : 1'b0;

    apb_vec_regs #(.DEPTH(DEPTH), .IDX_W(IDX_W)) u_regs (
        .clk            (clk),
        .reset_n        (reset_n),
        .apb_req_i      (apb_req_i),
        .apb_rsp_o      (apb_rsp_o),
        .busy_i         (busy),
        .done_i         (done),
        .start_o        (start),
        .cmd_o          (cmd),
        .bank_we_a_o    (reg_we_a),
        .bank_we_b_o    (reg_we_b),
        .bank_addr_o    (reg_addr),
        .bank_wdata_o   (reg_wdata),
        .bank_c_rdata_i (c_rdata),
        .bank_a_rdata_i (a_rdata),
        .bank_b_rdata_i (b_rdata)
    );

    coef_bank #(.DEPTH(DEPTH), .IDX_W(IDX_W)) u_bank_a (
        .clk     (clk),
        .we_i    (a_we),
        .waddr_i (reg_addr),
        .wdata_i (reg_wdata),
        .raddr_i (ab_raddr),
        .rdata_o (a_rdata)
    );

    coef_bank #(.DEPTH(DEPTH), .IDX_W(IDX_W)) u_bank_b (
        .clk     (clk),
        .we_i    (b_we),
        .waddr_i (reg_addr),
        .wdata_i (reg_wdata),
        .raddr_i (ab_raddr),
        .rdata_o (b_rdata)
    );

    // Bank C is written only by the sequencer, read only over APB
    coef_bank #(.DEPTH(DEPTH), .IDX_W(IDX_W)) u_bank_c (
        .clk     (clk),
        .we_i    (c_we),
        .waddr_i (seq_wr_addr),
        .wdata_i (seq_wr_data),
        .raddr_i (reg_addr),
        .rdata_o (c_rdata)
    );

    vec_sequencer #(.DEPTH(DEPTH), .IDX_W(IDX_W)) u_seq (
        .clk         (clk),
        .reset_n     (reset_n),
        .start_i     (start),
        .cmd_i       (cmd),
        .busy_o      (busy),
        .done_o      (done),
        .rd_addr_o   (seq_rd_addr),
        .a_data_i    (a_rdata),
        .b_data_i    (b_rdata),
        .op_o        (op),
        .op_valid_o  (op_valid),
        .res_i       (res),
        .res_valid_i (res_valid),
        .wr_en_o     (seq_wr_en),
        .wr_addr_o   (seq_wr_addr),
        .wr_data_o   (seq_wr_data)
    );

    mod_add_sub u_add_sub (
        .clk         (clk),
        .reset_n     (reset_n),
        .op_i        (op),
        .op_valid_i  (op_valid),
        .res_o       (res),
        .res_valid_o (res_valid)
    );

endmodule

// File: src/vec_sequencer.sv
`timescale 1ns/1ps
// Walks banks A and B from index 0 to count-1 and feeds the add/sub pipeline
// Results are written back to bank C at the index that travels with each item
module vec_sequencer #(
    parameter int DEPTH = 64,
    parameter int IDX_W = 6
) (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             start_i,
    input  mod_arith_pkg::vec_cmd_t          cmd_i,
    output logic                             busy_o,
    output logic                             done_o,
    output logic [IDX_W-1:0]                 rd_addr_o,
    input  logic [mod_arith_pkg::COEF_W-1:0] a_data_i,
    input  logic [mod_arith_pkg::COEF_W-1:0] b_data_i,
    output mod_arith_pkg::coef_op_t          op_o,
    output logic                             op_valid_o,
    input  logic [mod_arith_pkg::COEF_W-1:0] res_i,
    input  logic                             res_valid_i,
    output logic                             wr_en_o,
    output logic [IDX_W-1:0]                 wr_addr_o,
    output logic [mod_arith_pkg::COEF_W-1:0] wr_data_o
);

    // Latched command
    logic             sub_q;
    logic             mlkem_q;
    logic [IDX_W:0]   cnt;
    logic [IDX_W-1:0] last_q;

    // Read side
    logic             busy_q;
    logic             done_q;
    logic             rd_act;
    logic [IDX_W-1:0] rd_idx;
    logic             issue_q;

    // Results still to come back
    logic [IDX_W:0]   remain;

    // Write-back index with one entry per pipeline stage
    logic [IDX_W-1:0] iss_idx;
    logic [IDX_W-1:0] idx_p1;
    logic [IDX_W-1:0] idx_p2;

    // Count clamped to the bank depth
    assign cnt = (cmd_i.count > DEPTH) ? (IDX_W+1)'(DEPTH) : (IDX_W+1)'(cmd_i.count);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sub_q   <= 1'b0;
            mlkem_q <= 1'b0;
            last_q  <= '0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            rd_act  <= 1'b0;
            rd_idx  <= '0;
            issue_q <= 1'b0;
            remain  <= '0;
        end else begin
            done_q  <= 1'b0;
            // Issue lags the read address by the bank read cycle
            issue_q <= rd_act;
            if (start_i && !busy_q) begin
                sub_q   <= cmd_i.sub;
                mlkem_q <= cmd_i.mlkem;
                last_q  <= cnt[IDX_W-1:0] - 1'b1;
                remain  <= cnt;
                rd_idx  <= '0;
                // Empty vector finishes at once
                if (cnt == '0) begin
                    done_q <= 1'b1;
                end else begin
                    busy_q <= 1'b1;
                    rd_act <= 1'b1;
                end
            end else begin
                if (rd_act) begin
                    if (rd_idx == last_q) begin
                        rd_act <= 1'b0;
                    end else begin
                        rd_idx <= rd_idx + 1'b1;
                    end
                end
                // Last write-back ends the run
                if (res_valid_i) begin
                    remain <= remain - 1'b1;
                    if (remain == (IDX_W+1)'(1)) begin
                        busy_q <= 1'b0;
                        done_q <= 1'b1;
                    end
                end
            end
        end
    end

    // Index pipeline matched to issue and the two add/sub stages
    always_ff @(posedge clk) begin
        iss_idx <= rd_idx;
        idx_p1  <= iss_idx;
        idx_p2  <= idx_p1;
    end

    assign rd_addr_o  = rd_idx;
    assign op_o       = '{sub: sub_q, mlkem: mlkem_q, opa: a_data_i, opb: b_data_i};
    assign op_valid_o = issue_q;
    assign wr_en_o    = res_valid_i;
    assign wr_addr_o  = idx_p2;
    assign wr_data_o  = res_i;
    assign busy_o     = busy_q;
    assign done_o     = done_q;

endmodule

// File: verification/tb_mod_vec_unit.sv
`timescale 1ns/1ps
// Directed testbench for the vector modular add/sub unit
// Loads banks A and B over APB, runs vectors and checks bank C against a modular model
module tb_mod_vec_unit;

    localparam int DEPTH = 64;
    localparam int TIMEOUT = 1000;
    localparam int unsigned QD = 8380417;
    localparam int unsigned QK = 3329;

    logic                    clk;
    logic                    reset_n;
    mod_arith_pkg::apb_req_t apb_req;
    mod_arith_pkg::apb_rsp_t apb_rsp;

    integer      seed;
    logic [31:0] rd_val;
    // Operand vectors as loaded into banks A and B
    logic [23:0] va [DEPTH];
    logic [23:0] vb [DEPTH];

    mod_vec_unit #(.DEPTH(DEPTH)) UUT (
        .clk       (clk),
        .reset_n   (reset_n),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp)
    );

    // 8 ns clock
    always #4 clk = ~clk;

    // ====================
    // Reporting
    // ====================
    task automatic abort_run(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        $display("TB FAILED");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string name);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // ====================
    // Reference model and stimulus
    // ====================
    // (a+b) mod q or (a-b+q) mod q
    function automatic logic [31:0] mod_ref(input logic [23:0] a, input logic [23:0] b,
                                            input logic sub, input logic mlkem);
        int unsigned q;
        int unsigned ua;
        int unsigned ub;
        q  = mlkem ? QK : QD;
        ua = a;
        ub = b;
        if (sub) begin
            return (ua + q - ub) % q;
        end
        return (ua + ub) % q;
    endfunction

    // Random coefficient already reduced below the prime
    function automatic logic [23:0] rand_coef(input logic mlkem);
        logic [31:0] r;
        r = $random(seed);
        return 24'(r % (mlkem ? QK : QD));
    endfunction

    function automatic logic [31:0] ctrl_word(input logic sub, input logic mlkem,
                                              input int count);
        return {17'b0, 7'(count), 5'b0, mlkem, sub, 1'b1};
    endfunction

    task automatic fill_random(input int n, input logic mlkem);
        for (int i = 0; i < n; i++) begin
            va[i] = rand_coef(mlkem);
            vb[i] = rand_coef(mlkem);
        end
    endtask

    // ====================
    // APB access
    // ====================
    // One transfer with pready, prdata and pslverr sampled mid-cycle where they are stable
    task automatic apb_xfer(input logic write, input logic [11:0] addr, input logic [31:0] wdata,
                            input logic exp_err, output logic [31:0] rdata);
        int n;
        @(negedge clk);
        apb_req.paddr   = addr;
        apb_req.pwrite  = write;
        apb_req.pwdata  = wdata;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(negedge clk);
        apb_req.penable = 1'b1;
        n = 0;
        #2;
        while (apb_rsp.pready !== 1'b1) begin
            n++;
            if (n > TIMEOUT) begin
                abort_run($sformatf("APB transfer to 0x%03h never saw pready", addr));
            end
            @(negedge clk);
            #2;
        end
        rdata = apb_rsp.prdata;
        if (apb_rsp.pslverr !== exp_err) begin
            abort_run($sformatf("APB transfer to 0x%03h gave pslverr %b, wanted %b",
                                addr, apb_rsp.pslverr, exp_err));
        end
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, input logic exp_err);
        logic [31:0] unused_rd;
        apb_xfer(1'b1, addr, data, exp_err, unused_rd);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
        apb_xfer(1'b0, addr, 32'h0, 1'b0, data);
    endtask

    // ====================
    // Vector helpers
    // ====================
    task automatic load_banks(input int n);
        for (int i = 0; i < n; i++) begin
            apb_write(mod_arith_pkg::BANK_A_BASE + 12'(i * 4), 32'(va[i]), 1'b0);
            apb_write(mod_arith_pkg::BANK_B_BASE + 12'(i * 4), 32'(vb[i]), 1'b0);
        end
    endtask

    // Poll STATUS until the sticky done bit shows up
    task automatic wait_done();
        int n;
        n = 0;
        apb_read(mod_arith_pkg::REG_STATUS, rd_val);
        while (rd_val[1] !== 1'b1) begin
            n++;
            if (n > TIMEOUT) begin
                abort_run("STATUS done never set after start");
            end
            apb_read(mod_arith_pkg::REG_STATUS, rd_val);
        end
        check_eq(rd_val, 32'h2, "STATUS after done");
    endtask

    task automatic run_vector(input logic sub, input logic mlkem, input int count);
        apb_write(mod_arith_pkg::REG_CTRL, ctrl_word(sub, mlkem, count), 1'b0);
        wait_done();
    endtask

    task automatic check_bank(input int n, input logic sub, input logic mlkem);
        for (int i = 0; i < n; i++) begin
            apb_read(mod_arith_pkg::BANK_C_BASE + 12'(i * 4), rd_val);
            // ML-KEM results keep bits 31:12 clear
            if (mlkem) begin
                check_eq(32'(rd_val[31:12]), 32'h0, $sformatf("bank C[%0d] upper bits", i));
            end
            check_eq(rd_val, mod_ref(va[i], vb[i], sub, mlkem), $sformatf("bank C[%0d]", i));
        end
    endtask

    // ====================
    // Tests
    // ====================
    task automatic test_reset_state();
        apb_read(mod_arith_pkg::REG_STATUS, rd_val);
        check_eq(rd_val, 32'h0, "STATUS after reset");
        apb_read(mod_arith_pkg::REG_CTRL, rd_val);
        check_eq(32'(rd_val[0]), 32'h0, "CTRL start");
        check_eq(rd_val, 32'h0, "CTRL after reset");
    endtask

    task automatic test_mldsa_add();
        fill_random(16, 1'b0);
        va[16] = 24'(QD - 1);
        vb[16] = 24'(QD - 1);
        va[17] = 24'd0;
        vb[17] = 24'd0;
        load_banks(18);
        run_vector(1'b0, 1'b0, 18);
        check_bank(18, 1'b0, 1'b0);
    endtask

    task automatic test_mldsa_sub();
        fill_random(16, 1'b0);
        va[16] = 24'd0;
        vb[16] = 24'(QD - 1);
        va[17] = rand_coef(1'b0);
        vb[17] = va[17];
        load_banks(18);
        run_vector(1'b1, 1'b0, 18);
        check_bank(18, 1'b1, 1'b0);
    endtask

    task automatic test_mlkem();
        for (int s = 0; s < 2; s++) begin
            fill_random(16, 1'b1);
            // Pairs at the top of the ML-KEM range
            va[0] = 24'd3328;
            vb[0] = 24'd3328;
            va[1] = 24'd3328;
            vb[1] = 24'd0;
            va[2] = 24'd0;
            vb[2] = 24'd3328;
            load_banks(16);
            run_vector(s[0], 1'b1, 16);
            check_bank(16, s[0], 1'b1);
        end
    endtask

    task automatic test_busy_rules();
        fill_random(DEPTH, 1'b0);
        load_banks(DEPTH);
        apb_write(mod_arith_pkg::REG_CTRL, ctrl_word(1'b0, 1'b0, DEPTH), 1'b0);
        // Both land while the 64-entry run is still busy
        apb_write(mod_arith_pkg::BANK_A_BASE, 32'h0000_1234, 1'b1);
        apb_write(mod_arith_pkg::REG_CTRL, ctrl_word(1'b1, 1'b1, 5), 1'b1);
        wait_done();
        check_bank(DEPTH, 1'b0, 1'b0);
        apb_read(mod_arith_pkg::BANK_A_BASE, rd_val);
        check_eq(rd_val, 32'(va[0]), "bank A[0] after busy write");
        apb_write(mod_arith_pkg::BANK_C_BASE, 32'h5, 1'b1);
    endtask

    task automatic test_full_and_empty();
        fill_random(DEPTH, 1'b0);
        load_banks(DEPTH);
        run_vector(1'b1, 1'b0, DEPTH);
        check_bank(DEPTH, 1'b1, 1'b0);
        // Empty vector only sets done and leaves the last results in bank C
        run_vector(1'b0, 1'b0, 0);
        check_bank(DEPTH, 1'b1, 1'b0);
    endtask

    initial begin
        seed    = 32'h000d_b123;
        clk     = 1'b0;
        reset_n = 1'b0;
        apb_req = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        test_reset_state();
        test_mldsa_add();
        test_mldsa_sub();
        test_mlkem();
        test_busy_rules();
        test_full_and_empty();

        $display("TB PASSED");
        $finish;
    end

endmodule
